/* spdif_rx_top.f */
spdif_pkg.sv
spdif_dai.sv
spdif_cs_capture.sv
spdif_sample_port.sv
spdif_rx_top.sv
tb_clk_gen.sv
tb_spdif_rx.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_spdif_rx
RTL_TOP    ?= spdif_rx_top
FILELIST   ?= spdif_rx_top.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= -Wwarn-lint
PASS_MSG   ?= Regression passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* tb_spdif_rx.sv */
`timescale 1ns/1ps
// directed tests for the S/PDIF receiver at 4 clocks per bit cell
// line is driven as 2-clock half-cells; a biphase carrier precedes every frame stream
module tb_spdif_rx;

    localparam int sw = spdif_pkg::sample_width;

    logic          clk;
    logic          rst;
    logic          signal;
    logic          ack = 1'b0;
    logic          locked;
    logic [sw-1:0] pair_left;
    logic [sw-1:0] pair_right;
    logic          req;
    logic          overrun;
    logic [31:0]   cs_word;
    logic          cs_valid;

    logic          ack_hold;
    logic          line_lvl;
    int            frame_idx;
    int            errors;
    int            failed;
    int            test_err;
    logic [sw-1:0] got_left[$];
    logic [sw-1:0] got_right[$];
    logic [sw-1:0] exp_left[$];
    logic [sw-1:0] exp_right[$];

    tb_clk_gen clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    spdif_rx_top #(
        .clk_per_bit (4)
    ) dut_i (
        .clk        (clk),
        .rst        (rst),
        .signal     (signal),
        .ack        (ack),
        .locked     (locked),
        .pair_left  (pair_left),
        .pair_right (pair_right),
        .req        (req),
        .overrun    (overrun),
        .cs_word    (cs_word),
        .cs_valid   (cs_valid)
    );

    // consumer takes a pair as it raises ack, unless ack is withheld
    always @(negedge clk) begin
        if (!ack && req && !ack_hold) begin
            got_left.push_back(pair_left);
            got_right.push_back(pair_right);
            ack <= 1'b1;
        end else if (ack && !req) begin
            ack <= 1'b0;
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic drive_half(input logic v);
        repeat (2) begin
            @(negedge clk);
            signal = v;
        end
    endtask

    task automatic hold_line(input int clocks);
        repeat (clocks) begin
            @(negedge clk);
            signal = line_lvl;
        end
    endtask

    task automatic send_cell(input logic b);
        line_lvl = ~line_lvl;
        drive_half(line_lvl);
        if (b) begin
            line_lvl = ~line_lvl;
        end
        drive_half(line_lvl);
    endtask

    task automatic send_subframe(input spdif_pkg::preamble_t kind, input logic [sw-1:0] smp,
                                 input logic cs, input logic bad);
        logic [7:0]  code;
        logic [27:0] pay;
        case (kind)
            spdif_pkg::pre_b: code = 8'b1110_1000;
            spdif_pkg::pre_m: code = 8'b1110_0010;
            default:          code = 8'b1110_0100;
        endcase
        // preamble always opens with a transition
        if (line_lvl) begin
            code = ~code;
        end
        for (int i = 7; i >= 0; i--) begin
            drive_half(code[i]);
        end
        line_lvl = code[0];
        // validity and user bits stay 0
        pay = {1'b0, cs, 1'b0, 1'b0, smp};
        pay[27] = (^pay[26:0]) ^ bad;
        for (int i = 0; i < 28; i++) begin
            send_cell(pay[i]);
        end
    endtask

    // channel B carries the inverted cs bit, which the capture must ignore
    task automatic send_frame(input logic [sw-1:0] l, input logic [sw-1:0] r,
                              input logic cs, input logic bad_w);
        spdif_pkg::preamble_t kind;
        kind = spdif_pkg::pre_m;
        if (frame_idx == 0) begin
            kind = spdif_pkg::pre_b;
        end
        send_subframe(kind, l, cs, 1'b0);
        send_subframe(spdif_pkg::pre_w, r, ~cs, bad_w);
        frame_idx = (frame_idx + 1) % spdif_pkg::cs_block_frames;
    endtask

    // only the first keep frames are expected back, frame bad_at never
    task automatic send_random_frames(input int n, input int bad_at, input int keep,
                                      input logic [31:0] cs_pat);
        logic [sw-1:0] l;
        logic [sw-1:0] r;
        logic          cs;
        for (int i = 0; i < n; i++) begin
            l  = sw'($urandom());
            r  = sw'($urandom());
            cs = (i < 32) ? cs_pat[i] : 1'($urandom());
            send_frame(l, r, cs, i == bad_at);
            if (i != bad_at && i < keep) begin
                exp_left.push_back(l);
                exp_right.push_back(r);
            end
        end
    endtask

    // biphase zeros without preambles keep the start search armed
    task automatic begin_stream(output int base);
        for (int i = 0; i < 8; i++) begin
            send_cell(1'b0);
        end
        frame_idx = 0;
        exp_left.delete();
        exp_right.delete();
        base = got_left.size();
    endtask

    task automatic wait_pairs(input int base, input int limit);
        int n;
        n = 0;
        while ((got_left.size() - base < exp_left.size() || req || ack) && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (n >= limit) begin
            $display("timeout: sample pairs not delivered within %0d clocks", limit);
            errors++;
        end
        check_val("pair count", 32'(got_left.size() - base), 32'(exp_left.size()));
        for (int k = 0; k < exp_left.size() && base + k < got_left.size(); k++) begin
            check_val("pair_left", 32'(got_left[base + k]), 32'(exp_left[k]));
            check_val("pair_right", 32'(got_right[base + k]), 32'(exp_right[k]));
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_err) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_err);
            failed++;
        end
        test_err = errors;
    endtask

    task automatic test_lock();
        int base;
        hold_line(300);
        check_val("locked", 32'(locked), 32'd0);
        begin_stream(base);
        check_val("locked", 32'(locked), 32'd0);
        send_random_frames(1, -1, 1, 32'd0);
        check_val("locked", 32'(locked), 32'd1);
        wait_pairs(base, 64);
        end_test("lock");
    endtask

    task automatic test_pairs();
        int base;
        begin_stream(base);
        send_random_frames(8, -1, 8, $urandom());
        wait_pairs(base, 64);
        check_val("overrun", 32'(overrun), 32'd0);
        end_test("sample pairs");
    endtask

    task automatic test_parity();
        int base;
        begin_stream(base);
        send_random_frames(3, 1, 3, $urandom());
        wait_pairs(base, 64);
        end_test("parity");
    endtask

    task automatic test_backpressure();
        int base;
        begin_stream(base);
        ack_hold = 1'b1;
        send_random_frames(3, -1, 1, 32'd0);
        check_val("req", 32'(req), 32'd1);
        check_val("pair_left", 32'(pair_left), 32'(exp_left[0]));
        check_val("pair_right", 32'(pair_right), 32'(exp_right[0]));
        check_val("overrun", 32'(overrun), 32'd1);
        ack_hold = 1'b0;
        for (int i = 0; i < 8; i++) begin
            send_cell(1'b0);
        end
        frame_idx = 0;
        send_random_frames(2, -1, 2, 32'd0);
        wait_pairs(base, 64);
        end_test("back-pressure");
    endtask

    task automatic test_channel_status();
        int          base;
        int          n;
        logic [31:0] cs_pat;
        cs_pat = $urandom();
        check_val("cs_valid", 32'(cs_valid), 32'd0);
        begin_stream(base);
        send_random_frames(spdif_pkg::cs_block_frames, -1, spdif_pkg::cs_block_frames, cs_pat);
        n = 0;
        while (!cs_valid && n < 64) begin
            @(posedge clk);
            n++;
        end
        if (!cs_valid) begin
            $display("timeout: cs_valid did not rise after a full block");
            errors++;
        end
        check_val("cs_word", cs_word, cs_pat);
        wait_pairs(base, 64);
        end_test("channel status");
    endtask

    task automatic test_lock_loss();
        int base;
        begin_stream(base);
        send_random_frames(2, -1, 2, 32'd0);
        check_val("locked", 32'(locked), 32'd1);
        wait_pairs(base, 64);
        hold_line(256);
        check_val("locked", 32'(locked), 32'd0);
        begin_stream(base);
        send_random_frames(1, -1, 1, 32'd0);
        check_val("locked", 32'(locked), 32'd1);
        wait_pairs(base, 64);
        end_test("lock loss");
    endtask

    initial begin
        signal    = 1'b0;
        line_lvl  = 1'b0;
        ack_hold  = 1'b0;
        frame_idx = 0;
        errors    = 0;
        failed    = 0;
        test_err  = 0;
        void'($urandom(32'h8c00_bb03));
        for (int n = 0; rst !== 1'b0 && n < 20; n++) begin
            @(negedge clk);
        end
        if (rst !== 1'b0) begin
            $display("timeout: reset was not released");
            errors++;
        end
        test_lock();
        test_pairs();
        test_parity();
        test_backpressure();
        test_channel_status();
        test_lock_loss();
        $display("tests run 6, tests failed %0d, errors %0d", failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ps
// 100 ns clock, reset high for the first 5 rising edges, released on a falling edge
module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* spdif_rx_top.sv */
`timescale 1ns/1ps
// S/PDIF receiver top; clk_per_bit must be 4
// validity bit is decoded but not forwarded
module spdif_rx_top #(
    parameter int clk_per_bit = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                signal,
    input  logic                                ack,
    output logic                                locked,
    output logic [spdif_pkg::sample_width-1:0]  pair_left,
    output logic [spdif_pkg::sample_width-1:0]  pair_right,
    output logic                                req,
    output logic                                overrun,
    output logic [spdif_pkg::cs_word_bits-1:0]  cs_word,
    output logic                                cs_valid
);

    logic                               sub_valid;
    spdif_pkg::preamble_t               sub_kind;
    logic [spdif_pkg::sample_width-1:0] sub_sample;
    logic                               sub_cs_bit;

    spdif_dai #(
        .clk_per_bit (clk_per_bit)
    ) dai_i (
        .clk          (clk),
        .rst          (rst),
        .signal       (signal),
        .locked       (locked),
        .sub_valid    (sub_valid),
        .sub_kind     (sub_kind),
        .sub_sample   (sub_sample),
        .sub_validity (),
        .sub_cs_bit   (sub_cs_bit)
    );

    spdif_cs_capture cs_i (
        .clk        (clk),
        .rst        (rst),
        .sub_valid  (sub_valid),
        .sub_kind   (sub_kind),
        .sub_cs_bit (sub_cs_bit),
        .cs_word    (cs_word),
        .cs_valid   (cs_valid)
    );

    spdif_sample_port port_i (
        .clk        (clk),
        .rst        (rst),
        .sub_valid  (sub_valid),
        .sub_kind   (sub_kind),
        .sub_sample (sub_sample),
        .ack        (ack),
        .pair_left  (pair_left),
        .pair_right (pair_right),
        .req        (req),
        .overrun    (overrun)
    );

endmodule

/* spdif_sample_port.sv */
`timescale 1ns/1ps
// left/right pair register with a four-phase req/ack handshake
// single pair of storage; a pair completing while busy is lost and sets overrun
module spdif_sample_port (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                sub_valid,
    input  spdif_pkg::preamble_t                sub_kind,
    input  logic [spdif_pkg::sample_width-1:0]  sub_sample,
    input  logic                                ack,
    output logic [spdif_pkg::sample_width-1:0]  pair_left,
    output logic [spdif_pkg::sample_width-1:0]  pair_right,
    output logic                                req,
    output logic                                overrun
);

    typedef enum logic [1:0] {
        hs_idle,
        hs_req,
        hs_release
    } hs_state_t;

    hs_state_t hs_state;

    logic [spdif_pkg::sample_width-1:0] left_q;
    logic                               left_ok;
    logic                               take_left;
    logic                               pair_done;

    // B and M both open a frame on channel A
    assign take_left = sub_valid &&
                       (sub_kind == spdif_pkg::pre_b || sub_kind == spdif_pkg::pre_m);
    // W without a channel A sample before it is ignored
    assign pair_done = sub_valid && sub_kind == spdif_pkg::pre_w && left_ok;

    always_ff @(posedge clk) begin
        if (take_left) begin
            left_q <= sub_sample;
        end
        if (pair_done && hs_state == hs_idle) begin
            pair_left  <= left_q;
            pair_right <= sub_sample;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hs_state <= hs_idle;
            left_ok  <= 1'b0;
            overrun  <= 1'b0;
        end else begin
            if (take_left) begin
                left_ok <= 1'b1;
            end else if (pair_done) begin
                left_ok <= 1'b0;
            end

            case (hs_state)
                hs_idle: begin
                    if (pair_done) begin
                        hs_state <= hs_req;
                    end
                end
                hs_req: begin
                    if (ack) begin
                        hs_state <= hs_release;
                    end
                end
                hs_release: begin
                    // wait for the consumer to drop ack
                    if (!ack) begin
                        hs_state <= hs_idle;
                    end
                end
                default: hs_state <= hs_idle;
            endcase

            if (pair_done && hs_state != hs_idle) begin
                overrun <= 1'b1;
            end
        end
    end

    assign req = hs_state == hs_req;

endmodule

/* spdif_cs_capture.sv */
`timescale 1ns/1ps
// channel status capture from channel A, block aligned to the B preamble
// only the first 32 bits of a block are kept; cs_valid stays high once a block completes
module spdif_cs_capture (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 sub_valid,
    input  spdif_pkg::preamble_t                 sub_kind,
    input  logic                                 sub_cs_bit,
    output logic [spdif_pkg::cs_word_bits-1:0]   cs_word,
    output logic                                 cs_valid
);

    localparam int cnt_w = $clog2(spdif_pkg::cs_block_frames);
    localparam logic [cnt_w-1:0] last_frame = cnt_w'(spdif_pkg::cs_block_frames - 1);
    localparam logic [cnt_w-1:0] word_frames = cnt_w'(spdif_pkg::cs_word_bits);

    logic [cnt_w-1:0]                   frame_cnt;
    logic                               in_block;
    logic [spdif_pkg::cs_word_bits-1:0] cs_shift;
    logic                               is_b;
    logic                               is_m;

    assign is_b = sub_valid && sub_kind == spdif_pkg::pre_b;
    assign is_m = sub_valid && sub_kind == spdif_pkg::pre_m && in_block;

    // frame 0 ends up in bit 0 after 32 shifts
    always_ff @(posedge clk) begin
        if (is_b || (is_m && frame_cnt < word_frames)) begin
            cs_shift <= {sub_cs_bit, cs_shift[spdif_pkg::cs_word_bits-1:1]};
        end
        if (is_m && frame_cnt == last_frame) begin
            cs_word <= cs_shift;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_cnt <= '0;
            in_block  <= 1'b0;
            cs_valid  <= 1'b0;
        end else if (is_b) begin
            // B always starts a fresh block, short blocks are dropped
            frame_cnt <= cnt_w'(1);
            in_block  <= 1'b1;
        end else if (is_m) begin
            if (frame_cnt == last_frame) begin
                in_block <= 1'b0;
                cs_valid <= 1'b1;
            end else begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

endmodule

/* spdif_dai.sv */
`timescale 1ns/1ps
// biphase-mark subframe decoder, line sampled at a fixed 4 clocks per bit cell
// no clock recovery; phase is aligned once by the preamble search, then free-runs
module spdif_dai #(
    parameter int clk_per_bit = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                signal,
    output logic                                locked,
    output logic                                sub_valid,
    output spdif_pkg::preamble_t                sub_kind,
    output logic [spdif_pkg::sample_width-1:0]  sub_sample,
    output logic                                sub_validity,
    output logic                                sub_cs_bit
);

    localparam int half_cell = clk_per_bit / 2;
    localparam int sub_clks  = clk_per_bit * spdif_pkg::subframe_bits;
    localparam int phase_w   = $clog2(sub_clks);
    localparam int data_bits = spdif_pkg::subframe_bits - 4;

    localparam logic [phase_w-1:0] phase_run_end = phase_w'(half_cell * 3 - 1);
    localparam logic [phase_w-1:0] phase_pre_end = phase_w'(clk_per_bit * 4 - 1);
    localparam logic [phase_w-1:0] phase_sub_end = phase_w'(sub_clks - 1);

    // first half-cell in the msb, line low before the preamble
    localparam logic [7:0] code_b = 8'b1110_1000;
    localparam logic [7:0] code_m = 8'b1110_0010;
    localparam logic [7:0] code_w = 8'b1110_0100;

    spdif_pkg::lock_state_t state;
    spdif_pkg::preamble_t   pre_kind;
    spdif_pkg::preamble_t   kind_q;

    logic [phase_w-1:0]   phase;
    logic                 sig_d;
    logic [6:0]           hc_hist;
    logic [7:0]           pre_code;
    logic [data_bits-1:0] data_sr;
    logic [data_bits-1:0] data_next;
    logic                 half_end;
    logic                 cell_end;
    logic                 in_data;
    logic                 cell_bit;

    // sample points near the end of each half-cell and bit cell
    assign half_end = (int'(phase) % half_cell) == half_cell - 1;
    assign cell_end = (int'(phase) % clk_per_bit) == clk_per_bit - 1;
    assign in_data  = phase > phase_pre_end;

    // a cell carries a 1 when its two halves differ
    assign cell_bit  = signal ^ hc_hist[0];
    assign data_next = {cell_bit, data_sr[data_bits-1:1]};

    assign pre_code = {hc_hist, signal};

    always_comb begin
        case (pre_code)
            code_b, ~code_b: pre_kind = spdif_pkg::pre_b;
            code_m, ~code_m: pre_kind = spdif_pkg::pre_m;
            code_w, ~code_w: pre_kind = spdif_pkg::pre_w;
            default:         pre_kind = spdif_pkg::pre_none;
        endcase
    end

    // half-cell history and payload shift, lsb of the sample arrives first
    always_ff @(posedge clk) begin
        sig_d <= signal;
        if (half_end) begin
            hc_hist <= {hc_hist[5:0], signal};
        end
        if (cell_end && in_data) begin
            data_sr <= data_next;
        end
        if (phase == phase_pre_end) begin
            kind_q <= pre_kind;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= spdif_pkg::st_find_start;
            phase     <= '0;
            sub_valid <= 1'b0;
        end else begin
            sub_valid <= 1'b0;
            case (state)
                spdif_pkg::st_find_start: begin
                    // any edge restarts the run of three equal half-cells
                    if (signal != sig_d) begin
                        phase <= phase_w'(1);
                    end else begin
                        phase <= phase + 1'b1;
                        if (phase == phase_run_end) begin
                            state <= spdif_pkg::st_find_b;
                        end
                    end
                end
                spdif_pkg::st_find_b: begin
                    phase <= phase + 1'b1;
                    if (phase == phase_pre_end) begin
                        if (pre_kind == spdif_pkg::pre_b) begin
                            state <= spdif_pkg::st_locked;
                        end else begin
                            state <= spdif_pkg::st_find_start;
                            phase <= '0;
                        end
                    end
                end
                spdif_pkg::st_locked: begin
                    if (phase == phase_sub_end) begin
                        phase <= '0;
                        // even parity over cells 4..31, parity cell included
                        sub_valid <= ~(^data_next);
                    end else begin
                        phase <= phase + 1'b1;
                    end
                    if (phase == phase_pre_end && pre_kind == spdif_pkg::pre_none) begin
                        state <= spdif_pkg::st_find_start;
                        phase <= '0;
                    end
                end
                default: begin
                    state <= spdif_pkg::st_find_start;
                    phase <= '0;
                end
            endcase
        end
    end

    assign locked = state == spdif_pkg::st_locked;

    // layout after 28 cells: sample, V, U, C, P
    assign sub_kind     = kind_q;
    assign sub_sample   = data_sr[spdif_pkg::sample_width-1:0];
    assign sub_validity = data_sr[spdif_pkg::sample_width];
    assign sub_cs_bit   = data_sr[spdif_pkg::sample_width+2];

endmodule

/* spdif_pkg.sv */
// shared types and fixed IEC 60958 subframe constants for the S/PDIF receiver
// constants describe the standard frame layout and are not meant to be changed
package spdif_pkg;

    // decoder lock progress
    typedef enum logic [1:0] {
        st_find_start,
        st_find_b,
        st_locked
    } lock_state_t;

    // kind of preamble that opened a subframe
    // B and M both carry channel A, W carries channel B
    typedef enum logic [1:0] {
        pre_none,
        pre_b,
        pre_m,
        pre_w
    } preamble_t;

    // audio sample width, aux nibble folded in as the low bits
    localparam int sample_width = 24;

    // bit cells per subframe, preamble included
    localparam int subframe_bits = 32;

    // frames per channel status block
    localparam int cs_block_frames = 192;

    // channel status bits made visible to the user
    localparam int cs_word_bits = 32;

endpackage
